// File: hdl/noc_pkg.sv
package noc_pkg;

    localparam int NUM_NODES = 4;
    localparam int NUM_VCS   = 2;

    typedef logic [$clog2(NUM_NODES)-1:0] node_id_t;  // Node n of the network is index n-1.
    typedef logic [$clog2(NUM_VCS)-1:0]   vc_id_t;
    typedef logic [15:0]                  payload_t;
    typedef logic [1:0]                   port_id_t;  // Router port index, port 0 is local.

    // A packet is one flit, so head, body and tail are the same word.
    typedef struct packed {
        vc_id_t   vc;
        node_id_t dest;
        node_id_t src;
        payload_t payload;
    } flit_t;

    // Dimension-free routing for the fixed ring 1,2 -> 3 -> 4 -> 1,2.
    // Only node 4 has a second network output, which leads to node 2.
    function automatic port_id_t route_port(input node_id_t node,
                                            input int       num_outports,
                                            input node_id_t dest);
        if (dest == node) begin
            return port_id_t'(0);
        end
        if (node == node_id_t'(3) && dest == node_id_t'(1) && num_outports > 2) begin
            return port_id_t'(2);
        end
        return port_id_t'(1);
    endfunction

endpackage

// File: hdl/vc_buffer.sv
`timescale 1ns/100ps

module vc_buffer #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_pkg::flit_t               in,
    input  logic                         in_valid,
    input  logic [noc_pkg::NUM_VCS-1:0]  pop,
    output noc_pkg::flit_t               head [noc_pkg::NUM_VCS-1:0],
    output logic [noc_pkg::NUM_VCS-1:0]  head_valid,
    output logic [noc_pkg::NUM_VCS-1:0]  buffer_available
);
    import noc_pkg::*;

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
        flit_t            mem [BUFFER_SIZE];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             push;

        assign push = in_valid && (in.vc == vc_id_t'(v));  // The flit's own VC picks the FIFO.

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop[v]) begin
                    rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, pop[v]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= in;
            end
        end

        assign head[v]       = mem[rd_ptr];
        assign head_valid[v] = (count != '0);
    end

    // Every slot freed by a read goes back upstream as one credit, one cycle later.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buffer_available <= '0;
        end else begin
            buffer_available <= pop & head_valid;
        end
    end

endmodule

// File: hdl/credit_counter.sv
`timescale 1ns/100ps

module credit_counter #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sent,
    input  noc_pkg::vc_id_t              sent_vc,
    input  logic [noc_pkg::NUM_VCS-1:0]  credit_in,
    output logic [noc_pkg::NUM_VCS-1:0]  has_credit
);
    import noc_pkg::*;

    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
        logic [CNT_W-1:0] count;  // Free slots in the downstream FIFO of this VC.
        logic             take;

        assign take = sent && (sent_vc == vc_id_t'(v));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                count <= CNT_W'(BUFFER_SIZE);
            end else begin
                // A send and a returning credit in the same cycle cancel out.
                case ({take, credit_in[v]})
                    2'b10:   count <= count - 1'b1;
                    2'b01:   count <= count + 1'b1;
                    default: count <= count;
                endcase
            end
        end

        assign has_credit[v] = (count != '0);
    end

endmodule

// File: hdl/switch_allocator.sv
`timescale 1ns/100ps

module switch_allocator #(
    parameter int NUM_INPORTS  = 2,
    parameter int NUM_OUTPORTS = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [noc_pkg::NUM_VCS-1:0]  req_valid [NUM_INPORTS-1:0],
    input  noc_pkg::port_id_t            req_port  [NUM_INPORTS-1:0][noc_pkg::NUM_VCS-1:0],
    input  logic [noc_pkg::NUM_VCS-1:0]  out_ready [NUM_OUTPORTS-1:0],
    output logic [noc_pkg::NUM_VCS-1:0]  grant     [NUM_INPORTS-1:0]
);
    import noc_pkg::*;

    // Requesters are numbered input-major, so index i*NUM_VCS+v is input i, VC v.
    localparam int NUM_REQ = NUM_INPORTS * NUM_VCS;
    localparam int IDX_W   = $clog2(NUM_REQ);

    logic [IDX_W-1:0]        ptr     [NUM_OUTPORTS-1:0];  // Highest priority requester.
    logic [IDX_W-1:0]        win_idx [NUM_OUTPORTS-1:0];
    logic [NUM_OUTPORTS-1:0] win_valid;

    // Outputs are served in order. An input already granted to a lower
    // output is masked for the rest, so it pops at most one VC per cycle.
    always_comb begin
        logic [NUM_INPORTS-1:0] taken;
        int                     idx;
        int                     in_sel;
        int                     vc_sel;

        taken = '0;
        for (int i = 0; i < NUM_INPORTS; i++) begin
            grant[i] = '0;
        end

        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            win_valid[o] = 1'b0;
            win_idx[o]   = '0;
            for (int k = 0; k < NUM_REQ; k++) begin
                idx = int'(ptr[o]) + k;
                if (idx >= NUM_REQ) begin
                    idx = idx - NUM_REQ;
                end
                in_sel = idx / NUM_VCS;
                vc_sel = idx % NUM_VCS;
                if (!win_valid[o] && !taken[in_sel]
                        && req_valid[in_sel][vc_sel]
                        && (req_port[in_sel][vc_sel] == port_id_t'(o))
                        && out_ready[o][vc_sel]) begin
                    win_valid[o]             = 1'b1;
                    win_idx[o]               = IDX_W'(idx);
                    grant[in_sel][vc_sel]    = 1'b1;
                    taken[in_sel]            = 1'b1;
                end
            end
        end
    end

    // The winner drops to lowest priority on its output.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < NUM_OUTPORTS; o++) begin
                ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_OUTPORTS; o++) begin
                if (win_valid[o]) begin
                    ptr[o] <= (win_idx[o] == IDX_W'(NUM_REQ - 1)) ? '0 : win_idx[o] + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/noc_switch.sv
`timescale 1ns/100ps

module noc_switch #(
    parameter int                NUM_INPORTS  = 2,
    parameter int                NUM_OUTPORTS = 2,
    parameter int                BUFFER_SIZE  = 8,
    parameter noc_pkg::node_id_t NODE         = '0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_pkg::flit_t               in               [NUM_INPORTS-1:0],
    input  logic [NUM_INPORTS-1:0]       data_ready_in,
    input  logic                         packet_sent,
    input  logic [noc_pkg::NUM_VCS-1:0]  credit_in        [NUM_OUTPORTS-1:1],
    output noc_pkg::flit_t               out              [NUM_OUTPORTS-1:0],
    output logic [NUM_OUTPORTS-1:0]      data_ready_out,
    output logic [noc_pkg::NUM_VCS-1:0]  buffer_available [NUM_INPORTS-1:0]
);
    import noc_pkg::*;

    flit_t               head       [NUM_INPORTS-1:0][NUM_VCS-1:0];
    logic [NUM_VCS-1:0]  head_valid [NUM_INPORTS-1:0];
    port_id_t            req_port   [NUM_INPORTS-1:0][NUM_VCS-1:0];
    logic [NUM_VCS-1:0]  out_ready  [NUM_OUTPORTS-1:0];
    logic [NUM_VCS-1:0]  grant      [NUM_INPORTS-1:0];
    logic [NUM_OUTPORTS-1:0] out_load;
    flit_t               load_flit  [NUM_OUTPORTS-1:0];
    logic                local_free;

    for (genvar i = 0; i < NUM_INPORTS; i++) begin : g_in
        vc_buffer #(
            .BUFFER_SIZE(BUFFER_SIZE)
        ) i_vc_buffer (
            .clk             (clk),
            .rst_n           (rst_n),
            .in              (in[i]),
            .in_valid        (data_ready_in[i]),
            .pop             (grant[i]),
            .head            (head[i]),
            .head_valid      (head_valid[i]),
            .buffer_available(buffer_available[i])
        );
    end

    always_comb begin
        for (int i = 0; i < NUM_INPORTS; i++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                req_port[i][v] = route_port(NODE, NUM_OUTPORTS, head[i][v].dest);
            end
        end
    end

    // The endpoint has no credits. Its register is free when empty or draining now.
    assign local_free   = !data_ready_out[0] || packet_sent;
    assign out_ready[0] = {NUM_VCS{local_free}};

    for (genvar o = 1; o < NUM_OUTPORTS; o++) begin : g_credit
        credit_counter #(
            .BUFFER_SIZE(BUFFER_SIZE)
        ) i_credit_counter (
            .clk       (clk),
            .rst_n     (rst_n),
            .sent      (out_load[o]),
            .sent_vc   (load_flit[o].vc),
            .credit_in (credit_in[o]),
            .has_credit(out_ready[o])
        );
    end

    switch_allocator #(
        .NUM_INPORTS (NUM_INPORTS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) i_switch_allocator (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(head_valid),
        .req_port (req_port),
        .out_ready(out_ready),
        .grant    (grant)
    );

    // At most one grant targets each output, so this is a plain mux.
    always_comb begin
        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            out_load[o]  = 1'b0;
            load_flit[o] = '0;
            for (int i = 0; i < NUM_INPORTS; i++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    if (grant[i][v] && (req_port[i][v] == port_id_t'(o))) begin
                        out_load[o]  = 1'b1;
                        load_flit[o] = head[i][v];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_OUTPORTS; o++) begin
            if (out_load[o]) begin
                out[o] <= load_flit[o];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ready_out <= '0;
        end else begin
            for (int o = 0; o < NUM_OUTPORTS; o++) begin
                if (o == 0) begin
                    data_ready_out[o] <= out_load[o] || (data_ready_out[o] && !packet_sent);
                end else begin
                    data_ready_out[o] <= out_load[o];  // Links carry a one-cycle strobe.
                end
            end
        end
    end

endmodule

// File: hdl/noc_fabric.sv
`timescale 1ns/100ps

module noc_fabric #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  noc_pkg::flit_t in_flit          [noc_pkg::NUM_NODES-1:0],
    input  logic           data_ready_in    [noc_pkg::NUM_NODES-1:0],
    input  logic           packet_sent      [noc_pkg::NUM_NODES-1:0],
    output noc_pkg::flit_t out              [noc_pkg::NUM_NODES-1:0],
    output logic           data_ready_out   [noc_pkg::NUM_NODES-1:0],
    output logic           buffer_available [noc_pkg::NUM_VCS*noc_pkg::NUM_NODES-1:0]
);
    import noc_pkg::*;

    // Node 1 (index 0) takes its endpoint and node 4's port 1, and feeds node 3.
    flit_t              r0_in       [1:0];
    logic [1:0]         r0_valid_in;
    flit_t              r0_out      [1:0];
    logic [1:0]         r0_valid_out;
    logic [NUM_VCS-1:0] r0_ba       [1:0];
    logic [NUM_VCS-1:0] r0_credit   [1:1];

    // Node 2 (index 1) takes its endpoint and node 4's port 2, and feeds node 3.
    flit_t              r1_in       [1:0];
    logic [1:0]         r1_valid_in;
    flit_t              r1_out      [1:0];
    logic [1:0]         r1_valid_out;
    logic [NUM_VCS-1:0] r1_ba       [1:0];
    logic [NUM_VCS-1:0] r1_credit   [1:1];

    // Node 3 (index 2) merges nodes 1 and 2 and feeds node 4.
    flit_t              r2_in       [2:0];
    logic [2:0]         r2_valid_in;
    flit_t              r2_out      [1:0];
    logic [1:0]         r2_valid_out;
    logic [NUM_VCS-1:0] r2_ba       [2:0];
    logic [NUM_VCS-1:0] r2_credit   [1:1];

    // Node 4 (index 3) fans out to nodes 1 and 2.
    flit_t              r3_in       [1:0];
    logic [1:0]         r3_valid_in;
    flit_t              r3_out      [2:0];
    logic [2:0]         r3_valid_out;
    logic [NUM_VCS-1:0] r3_ba       [1:0];
    logic [NUM_VCS-1:0] r3_credit   [2:1];

    assign r0_in[0]    = in_flit[0];
    assign r0_in[1]    = r3_out[1];
    assign r0_valid_in = {r3_valid_out[1], data_ready_in[0]};
    assign r0_credit[1] = r2_ba[1];

    assign r1_in[0]    = in_flit[1];
    assign r1_in[1]    = r3_out[2];
    assign r1_valid_in = {r3_valid_out[2], data_ready_in[1]};
    assign r1_credit[1] = r2_ba[2];

    assign r2_in[0]    = in_flit[2];
    assign r2_in[1]    = r0_out[1];
    assign r2_in[2]    = r1_out[1];
    assign r2_valid_in = {r1_valid_out[1], r0_valid_out[1], data_ready_in[2]};
    assign r2_credit[1] = r3_ba[1];

    assign r3_in[0]    = in_flit[3];
    assign r3_in[1]    = r2_out[1];
    assign r3_valid_in = {r2_valid_out[1], data_ready_in[3]};
    assign r3_credit[1] = r0_ba[1];
    assign r3_credit[2] = r1_ba[1];

    noc_switch #(.NUM_INPORTS(2), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE), .NODE(2'd0))
    i_switch0 (.clk(clk), .rst_n(rst_n), .in(r0_in), .data_ready_in(r0_valid_in),
               .packet_sent(packet_sent[0]), .credit_in(r0_credit), .out(r0_out),
               .data_ready_out(r0_valid_out), .buffer_available(r0_ba));

    noc_switch #(.NUM_INPORTS(2), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE), .NODE(2'd1))
    i_switch1 (.clk(clk), .rst_n(rst_n), .in(r1_in), .data_ready_in(r1_valid_in),
               .packet_sent(packet_sent[1]), .credit_in(r1_credit), .out(r1_out),
               .data_ready_out(r1_valid_out), .buffer_available(r1_ba));

    noc_switch #(.NUM_INPORTS(3), .NUM_OUTPORTS(2), .BUFFER_SIZE(BUFFER_SIZE), .NODE(2'd2))
    i_switch2 (.clk(clk), .rst_n(rst_n), .in(r2_in), .data_ready_in(r2_valid_in),
               .packet_sent(packet_sent[2]), .credit_in(r2_credit), .out(r2_out),
               .data_ready_out(r2_valid_out), .buffer_available(r2_ba));

    noc_switch #(.NUM_INPORTS(2), .NUM_OUTPORTS(3), .BUFFER_SIZE(BUFFER_SIZE), .NODE(2'd3))
    i_switch3 (.clk(clk), .rst_n(rst_n), .in(r3_in), .data_ready_in(r3_valid_in),
               .packet_sent(packet_sent[3]), .credit_in(r3_credit), .out(r3_out),
               .data_ready_out(r3_valid_out), .buffer_available(r3_ba));

    assign out[0] = r0_out[0];
    assign out[1] = r1_out[0];
    assign out[2] = r2_out[0];
    assign out[3] = r3_out[0];

    assign data_ready_out[0] = r0_valid_out[0];
    assign data_ready_out[1] = r1_valid_out[0];
    assign data_ready_out[2] = r2_valid_out[0];
    assign data_ready_out[3] = r3_valid_out[0];

    // Endpoint credits are grouped by node, VC 0 lowest within each group.
    for (genvar v = 0; v < NUM_VCS; v++) begin : g_local_credit
        assign buffer_available[0*NUM_VCS + v] = r0_ba[0][v];
        assign buffer_available[1*NUM_VCS + v] = r1_ba[0][v];
        assign buffer_available[2*NUM_VCS + v] = r2_ba[0][v];
        assign buffer_available[3*NUM_VCS + v] = r3_ba[0][v];
    end

endmodule

// File: tb/noc_vectors.svh
// Burst table. Columns: start cycle, source node index, VC, destination mask
// (bit n selects node index n), flits per destination, cycles between flits.
localparam int NUM_BURSTS = 20;

int bursts [NUM_BURSTS][6] = '{
    '{  2, 0, 1, 4'b0001, 2, 2},  // Local turnaround on every node.
    '{  2, 1, 1, 4'b0010, 2, 2},
    '{  2, 2, 1, 4'b0100, 2, 2},
    '{  2, 3, 1, 4'b1000, 2, 2},
    '{ 10, 0, 0, 4'b1111, 2, 3},  // Every source to every destination.
    '{ 11, 0, 1, 4'b1111, 2, 3},
    '{ 11, 1, 0, 4'b1111, 2, 3},
    '{ 12, 1, 1, 4'b1111, 2, 3},
    '{ 12, 2, 0, 4'b1111, 2, 3},
    '{ 13, 2, 1, 4'b1111, 2, 3},
    '{ 13, 3, 0, 4'b1111, 2, 3},
    '{ 14, 3, 1, 4'b1111, 2, 3},
    // All four nodes flood node index 2 in the same cycles.
    '{200, 0, 0, 4'b0100, 8, 1},
    '{200, 0, 1, 4'b0100, 8, 1},
    '{200, 1, 0, 4'b0100, 8, 1},
    '{200, 1, 1, 4'b0100, 8, 1},
    '{200, 2, 0, 4'b0100, 8, 1},
    '{200, 2, 1, 4'b0100, 8, 1},
    '{200, 3, 0, 4'b0100, 8, 1},
    '{200, 3, 1, 4'b0100, 8, 1}
};

// Back-pressure windows. Columns: node index, first cycle, last cycle.
localparam int NUM_WINDOWS = 3;

int windows [NUM_WINDOWS][3] = '{
    '{3,  15,  40},
    '{0,  20,  70},
    '{2, 205, 260}   // Holds the flooded node while its buffers fill.
};

// File: tb/noc_fabric_tb.sv
`timescale 1ns/100ps

module noc_fabric_tb;
    import noc_pkg::*;

    localparam int BUFFER_SIZE = 8;

    `include "noc_vectors.svh"

    logic  clk;
    logic  rst_n;
    flit_t in_flit          [NUM_NODES-1:0];
    logic  data_ready_in    [NUM_NODES-1:0];
    logic  packet_sent      [NUM_NODES-1:0];
    flit_t out              [NUM_NODES-1:0];
    logic  data_ready_out   [NUM_NODES-1:0];
    logic  buffer_available [NUM_VCS*NUM_NODES-1:0];

    int    row_cycle [$];  // Expanded table with one entry per flit.
    flit_t row_flit  [$];
    flit_t pending   [NUM_NODES][$];  // Released flits that wait for a credit.
    flit_t expected  [NUM_NODES][NUM_NODES][NUM_VCS][$];
    int    credits   [NUM_NODES][NUM_VCS];
    int    injected  [NUM_NODES][NUM_VCS];
    int    returned  [NUM_NODES][NUM_VCS];
    logic  prev_valid [NUM_NODES];
    flit_t prev_out   [NUM_NODES];
    int    seed = 32'hcb20_3b94;
    int    cycle;
    int    delivered;
    int    data_errors;
    int    order_errors;
    int    hold_errors;
    int    credit_errors;

    noc_fabric #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) i_noc_fabric (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_flit         (in_flit),
        .data_ready_in   (data_ready_in),
        .packet_sent     (packet_sent),
        .out             (out),
        .data_ready_out  (data_ready_out),
        .buffer_available(buffer_available)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Each burst becomes single flits. The payload keeps the burst and its flit number.
    task automatic build_table();
        flit_t f;
        int    k;
        for (int b = 0; b < NUM_BURSTS; b++) begin
            k = 0;
            for (int r = 0; r < bursts[b][4]; r++) begin
                for (int d = 0; d < NUM_NODES; d++) begin
                    if (((bursts[b][3] >> d) & 1) != 0) begin
                        f.vc      = vc_id_t'(bursts[b][2]);
                        f.dest    = node_id_t'(d);
                        f.src     = node_id_t'(bursts[b][1]);
                        f.payload = payload_t'(b * 256 + k);
                        row_cycle.push_back(bursts[b][0] + k * bursts[b][5]);
                        row_flit.push_back(f);
                        k++;
                    end
                end
            end
        end
    endtask

    function automatic bit in_window(int node, int now);
        for (int w = 0; w < NUM_WINDOWS; w++) begin
            if (windows[w][0] == node && now >= windows[w][1] && now <= windows[w][2]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic release_rows();
        flit_t f;
        for (int r = 0; r < row_cycle.size(); r++) begin
            if (row_cycle[r] == cycle) begin
                f = row_flit[r];
                pending[f.src].push_back(f);
                expected[f.src][f.dest][f.vc].push_back(f);  // Queues keep table order.
            end
        end
    endtask

    task automatic collect_credits();
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (buffer_available[n*NUM_VCS + v]) begin
                    returned[n][v]++;
                    credits[n][v]++;
                    assert (credits[n][v] <= BUFFER_SIZE) else begin
                        credit_errors++;
                        $display("[ERROR] %0t: node %0d VC %0d got a credit it never spent",
                                 $time, n, v);
                    end
                end
            end
        end
    endtask

    // An endpoint sends the oldest released flit whose VC still holds a credit.
    task automatic inject_flits();
        int pick;
        for (int n = 0; n < NUM_NODES; n++) begin
            pick = -1;
            for (int i = 0; i < pending[n].size(); i++) begin
                if (pick < 0 && credits[n][pending[n][i].vc] > 0) begin
                    pick = i;
                end
            end
            data_ready_in[n] = (pick >= 0);
            if (pick >= 0) begin
                in_flit[n] = pending[n][pick];
                credits[n][in_flit[n].vc]--;
                injected[n][in_flit[n].vc]++;
                pending[n].delete(pick);
            end
        end
    endtask

    // Only the destination is checked, not the route. A flit leaves on port 0 at its
    // own node, on port 2 at node 4 when bound for node 2, and on port 1 otherwise.
    task automatic score_flit(int node, flit_t f);
        assert (f.dest == node_id_t'(node)) else begin
            data_errors++;
            $display("[ERROR] %0t: node %0d received a flit for node %0d", $time, node, f.dest);
        end
        assert (expected[f.src][f.dest][f.vc].size() > 0) else begin
            data_errors++;
            $display("[ERROR] %0t: node %0d received unexpected flit %h", $time, node, f);
        end
        if (expected[f.src][f.dest][f.vc].size() > 0) begin
            assert (expected[f.src][f.dest][f.vc][0] == f) else begin
                order_errors++;
                $display("[ERROR] %0t: node %0d received flit %h, expected %h",
                         $time, node, f, expected[f.src][f.dest][f.vc][0]);
            end
            expected[f.src][f.dest][f.vc].delete(0);
        end
        delivered++;
    endtask

    // Outputs are read here, half a cycle after the edge that set them.
    task automatic drive_ejection();
        bit ready;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (prev_valid[n] && !packet_sent[n]) begin
                assert (data_ready_out[n] && out[n] == prev_out[n]) else begin
                    hold_errors++;
                    $display("[ERROR] %0t: node %0d dropped or changed a held flit", $time, n);
                end
            end
            ready = ($random(seed) & 3) != 0;
            if (in_window(n, cycle)) begin
                ready = 1'b0;
            end
            if (data_ready_out[n] && ready) begin
                score_flit(n, out[n]);  // The next rising edge completes this transfer.
            end
            prev_valid[n]  = data_ready_out[n];
            prev_out[n]    = out[n];
            packet_sent[n] = ready;
        end
    endtask

    task automatic final_checks();
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                assert (returned[n][v] == injected[n][v]) else begin
                    credit_errors++;
                    $display("[ERROR] %0t: node %0d VC %0d injected %0d flits but got %0d credits",
                             $time, n, v, injected[n][v], returned[n][v]);
                end
                for (int d = 0; d < NUM_NODES; d++) begin
                    assert (expected[n][d][v].size() == 0) else begin
                        data_errors++;
                        $display("[ERROR] %0t: %0d flits from node %0d to node %0d never arrived",
                                 $time, expected[n][d][v].size(), n, d);
                    end
                end
            end
        end
    endtask

    initial begin
        bit timed_out;
        int last;
        int limit;
        int drain;
        int total;

        timed_out = 1'b0;
        rst_n     = 1'b0;
        delivered = 0;
        for (int n = 0; n < NUM_NODES; n++) begin
            in_flit[n]       = '0;
            data_ready_in[n] = 1'b0;
            packet_sent[n]   = 1'b0;
            prev_valid[n]    = 1'b0;
            prev_out[n]      = '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                credits[n][v]  = BUFFER_SIZE;
                injected[n][v] = 0;
                returned[n][v] = 0;
            end
        end
        build_table();
        last = 0;
        foreach (row_cycle[r]) begin
            last = (row_cycle[r] > last) ? row_cycle[r] : last;
        end
        limit = last + 40 * row_cycle.size();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        cycle = 0;
        drain = 0;
        // A few extra cycles after the last delivery let the final credits come home.
        while (drain < 4 && !timed_out) begin
            @(negedge clk);
            cycle++;
            collect_credits();
            drive_ejection();
            release_rows();
            inject_flits();
            if (cycle > last && delivered >= row_cycle.size()) begin
                drain++;
            end
            if (cycle > limit) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Timeout: injection or delivery stalled past cycle %0d.", limit);
        end else begin
            final_checks();
        end
        total = data_errors + order_errors + hold_errors + credit_errors;
        $display("Errors: data %0d, order %0d, hold %0d, credit %0d, flits delivered %0d of %0d",
                 data_errors, order_errors, hold_errors, credit_errors, delivered,
                 row_cycle.size());
        if (!timed_out && total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+tb
hdl/noc_pkg.sv
hdl/vc_buffer.sv
hdl/credit_counter.sv
hdl/switch_allocator.sv
hdl/noc_switch.sv
hdl/noc_fabric.sv
tb/noc_fabric_tb.sv

// File: Makefile
SOURCES = $(filter-out +%,$(shell cat compile.f)) tb/noc_vectors.svh

all: run

obj_dir/Vnoc_fabric_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module noc_fabric_tb -f compile.f

run: obj_dir/Vnoc_fabric_tb
	obj_dir/Vnoc_fabric_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
